// ==== common/exec_pkg.sv ====
package exec_pkg;

  // Datapath and register file geometry
  localparam int xlen       = 32;
  localparam int reg_count  = 32;
  localparam int reg_addr_w = 5;

  localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

  // ALU operations
  typedef enum logic [4:0] {
    alu_imm   = 5'd0,
    alu_add   = 5'd1,
    alu_sub   = 5'd2,
    alu_and   = 5'd3,
    alu_xor   = 5'd4,
    alu_or    = 5'd5,
    alu_sl    = 5'd6,
    alu_sr    = 5'd7,
    alu_div   = 5'd8,
    alu_ssr   = 5'd9,
    alu_sles  = 5'd10,
    alu_ules  = 5'd11,
    alu_remu  = 5'd12,
    alu_mul   = 5'd13,
    alu_divu  = 5'd14,
    alu_rem   = 5'd15,
    // Code 16 unused
    alu_mulhu = 5'd17
  } alu_op_e;

  // RV32 major opcodes handled by the decoder
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011
  } opcode_e;

  // First ALU operand source
  typedef enum logic [1:0] {
    src1_rs1  = 2'd0,
    src1_pc   = 2'd1,
    src1_zero = 2'd2
  } src1_sel_e;

  // Control-flow kind
  // Signed and unsigned compares differ only in the ALU opcode
  typedef enum logic [2:0] {
    br_none = 3'd0,
    br_jal  = 3'd1,
    br_jalr = 3'd2,
    br_eq   = 3'd3,
    br_ne   = 3'd4,
    br_lt   = 3'd5,
    br_ge   = 3'd6
  } branch_e;

endpackage

// ==== exu/exu.sv ====
module exu (
  input  logic [exec_pkg::xlen-1:0] src1,
  input  logic [exec_pkg::xlen-1:0] src2,
  input  exec_pkg::alu_op_e         alu_op,
  output logic [exec_pkg::xlen-1:0] alu_result,
  output logic                      zero
);

  import exec_pkg::*;

  logic [4:0]        shamt;
  logic [xlen:0]     ules_diff;
  logic [2*xlen-1:0] prod_u;
  logic              div_by_zero;
  logic              sgn_ovf;

  assign shamt = src2[4:0];

  // Borrow out of the widened subtract gives the unsigned compare
  assign ules_diff = {1'b0, src1} - {1'b0, src2};

  assign prod_u = {{xlen{1'b0}}, src1} * {{xlen{1'b0}}, src2};

  assign div_by_zero = (src2 == '0);

  // Most negative value divided by -1
  assign sgn_ovf = (src1 == {1'b1, {(xlen-1){1'b0}}}) && (src2 == '1);

  always_comb begin
    case (alu_op)
      alu_imm:   alu_result = src2;
      alu_add:   alu_result = src1 + src2;
      alu_sub:   alu_result = src1 - src2;
      alu_and:   alu_result = src1 & src2;
      alu_xor:   alu_result = src1 ^ src2;
      alu_or:    alu_result = src1 | src2;
      alu_sl:    alu_result = src1 << shamt;
      alu_sr:    alu_result = src1 >> shamt;
      alu_ssr:   alu_result = $signed(src1) >>> shamt;
      alu_sles:  alu_result = {{(xlen-1){1'b0}}, $signed(src1) < $signed(src2)};
      alu_ules:  alu_result = {{(xlen-1){1'b0}}, ules_diff[xlen]};
      alu_mul:   alu_result = prod_u[xlen-1:0];
      alu_mulhu: alu_result = prod_u[2*xlen-1:xlen];
      alu_div: begin
        if (div_by_zero) begin
          alu_result = '1;
        end else if (sgn_ovf) begin
          alu_result = src1;
        end else begin
          alu_result = $signed(src1) / $signed(src2);
        end
      end
      alu_divu: begin
        if (div_by_zero) begin
          alu_result = '1;
        end else begin
          alu_result = src1 / src2;
        end
      end
      alu_rem: begin
        if (div_by_zero) begin
          alu_result = src1;
        end else if (sgn_ovf) begin
          alu_result = '0;
        end else begin
          alu_result = $signed(src1) % $signed(src2);
        end
      end
      alu_remu: begin
        if (div_by_zero) begin
          alu_result = src1;
        end else begin
          alu_result = src1 % src2;
        end
      end
      default: alu_result = '0;
    endcase
  end

  // Only add and sub report a zero result
  assign zero = ((alu_op == alu_add) || (alu_op == alu_sub)) && (alu_result == '0);

endmodule

// ==== design/idu.sv ====
module idu (
  input  logic [31:0]                    inst,
  output logic [exec_pkg::reg_addr_w-1:0] rs1,
  output logic [exec_pkg::reg_addr_w-1:0] rs2,
  output logic [exec_pkg::reg_addr_w-1:0] rd,
  output logic [exec_pkg::xlen-1:0]       imm,
  output exec_pkg::src1_sel_e             src1_sel,
  output logic                            src2_is_imm,
  output exec_pkg::alu_op_e               alu_op,
  output exec_pkg::branch_e               branch,
  output logic                            reg_write,
  output logic                            illegal
);

  import exec_pkg::*;

  opcode_e          opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [xlen-1:0]  imm_i;
  logic [xlen-1:0]  imm_u;
  logic [xlen-1:0]  imm_b;
  logic [xlen-1:0]  imm_j;

  assign opcode = opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign rd  = inst[11:7];
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];

  // Immediate formats
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    src1_sel    = src1_rs1;
    src2_is_imm = 1'b0;
    alu_op      = alu_add;
    branch      = br_none;
    reg_write   = 1'b0;
    illegal     = 1'b0;
    imm         = imm_i;

    case (opcode)
      op_lui: begin
        imm         = imm_u;
        src1_sel    = src1_zero;
        src2_is_imm = 1'b1;
        alu_op      = alu_imm;
        reg_write   = 1'b1;
      end
      op_auipc: begin
        imm         = imm_u;
        src1_sel    = src1_pc;
        src2_is_imm = 1'b1;
        reg_write   = 1'b1;
      end
      // Link value is pc + 4 with operand 2 from the core
      op_jal: begin
        imm       = imm_j;
        src1_sel  = src1_pc;
        branch    = br_jal;
        reg_write = 1'b1;
      end
      op_jalr: begin
        src1_sel  = src1_pc;
        branch    = br_jalr;
        reg_write = 1'b1;
        illegal   = (funct3 != 3'b000);
      end
      op_branch: begin
        imm = imm_b;
        case (funct3)
          3'b000: begin
            alu_op = alu_sub;
            branch = br_eq;
          end
          3'b001: begin
            alu_op = alu_sub;
            branch = br_ne;
          end
          3'b100: begin
            alu_op = alu_sles;
            branch = br_lt;
          end
          3'b101: begin
            alu_op = alu_sles;
            branch = br_ge;
          end
          3'b110: begin
            alu_op = alu_ules;
            branch = br_lt;
          end
          3'b111: begin
            alu_op = alu_ules;
            branch = br_ge;
          end
          default: illegal = 1'b1;
        endcase
      end
      op_imm: begin
        src2_is_imm = 1'b1;
        reg_write   = 1'b1;
        case (funct3)
          3'b000: alu_op = alu_add;
          3'b010: alu_op = alu_sles;
          3'b011: alu_op = alu_ules;
          3'b100: alu_op = alu_xor;
          3'b110: alu_op = alu_or;
          3'b111: alu_op = alu_and;
          3'b001: begin
            alu_op  = alu_sl;
            illegal = (funct7 != 7'b0000000);
          end
          default: begin
            // funct7 picks logical or arithmetic shift right
            if (funct7 == 7'b0000000) begin
              alu_op = alu_sr;
            end else if (funct7 == 7'b0100000) begin
              alu_op = alu_ssr;
            end else begin
              illegal = 1'b1;
            end
          end
        endcase
      end
      op_reg: begin
        reg_write = 1'b1;
        case (funct7)
          7'b0000000: begin
            case (funct3)
              3'b000: alu_op = alu_add;
              3'b001: alu_op = alu_sl;
              3'b010: alu_op = alu_sles;
              3'b011: alu_op = alu_ules;
              3'b100: alu_op = alu_xor;
              3'b101: alu_op = alu_sr;
              3'b110: alu_op = alu_or;
              default: alu_op = alu_and;
            endcase
          end
          7'b0100000: begin
            case (funct3)
              3'b000: alu_op = alu_sub;
              3'b101: alu_op = alu_ssr;
              default: illegal = 1'b1;
            endcase
          end
          // M extension without MULH and MULHSU
          7'b0000001: begin
            case (funct3)
              3'b000: alu_op = alu_mul;
              3'b011: alu_op = alu_mulhu;
              3'b100: alu_op = alu_div;
              3'b101: alu_op = alu_divu;
              3'b110: alu_op = alu_rem;
              3'b111: alu_op = alu_remu;
              default: illegal = 1'b1;
            endcase
          end
          default: illegal = 1'b1;
        endcase
      end
      default: illegal = 1'b1;
    endcase

    if (illegal) begin
      reg_write = 1'b0;
      branch    = br_none;
    end
  end

endmodule

// ==== design/regfile.sv ====
module regfile (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [exec_pkg::reg_addr_w-1:0] rs1,
  input  logic [exec_pkg::reg_addr_w-1:0] rs2,
  output logic [exec_pkg::xlen-1:0]       rs1_data,
  output logic [exec_pkg::xlen-1:0]       rs2_data,
  input  logic                            we,
  input  logic [exec_pkg::reg_addr_w-1:0] rd,
  input  logic [exec_pkg::xlen-1:0]       rd_data
);

  import exec_pkg::*;

  // No storage for x0
  logic [xlen-1:0] regs [1:reg_count-1];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== design/core_exec.sv ====
module core_exec (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            inst_valid,
  input  logic [31:0]                     inst,
  output logic [exec_pkg::xlen-1:0]       pc,
  output logic                            wb_en,
  output logic [exec_pkg::reg_addr_w-1:0] wb_rd,
  output logic [exec_pkg::xlen-1:0]       wb_data,
  output logic                            illegal
);

  import exec_pkg::*;

  logic [reg_addr_w-1:0] rs1_idx;
  logic [reg_addr_w-1:0] rs2_idx;
  logic [reg_addr_w-1:0] rd_idx;
  logic [xlen-1:0]       imm;
  src1_sel_e             src1_sel;
  logic                  src2_is_imm;
  alu_op_e               alu_op;
  branch_e               branch;
  logic                  reg_write;
  logic                  dec_illegal;

  logic [xlen-1:0]       rs1_data;
  logic [xlen-1:0]       rs2_data;
  logic [xlen-1:0]       src1;
  logic [xlen-1:0]       src2;
  logic [xlen-1:0]       alu_result;
  logic                  zero;

  logic                  is_jump;
  logic                  taken;
  logic [xlen-1:0]       jalr_sum;
  logic [xlen-1:0]       next_pc;

  idu u_idu (
    .inst        (inst),
    .rs1         (rs1_idx),
    .rs2         (rs2_idx),
    .rd          (rd_idx),
    .imm         (imm),
    .src1_sel    (src1_sel),
    .src2_is_imm (src2_is_imm),
    .alu_op      (alu_op),
    .branch      (branch),
    .reg_write   (reg_write),
    .illegal     (dec_illegal)
  );

  regfile u_regfile (
    .clk      (clk),
    .reset    (reset),
    .rs1      (rs1_idx),
    .rs2      (rs2_idx),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (wb_en),
    .rd       (wb_rd),
    .rd_data  (wb_data)
  );

  // Jumps compute the link value pc + 4
  assign is_jump = (branch == br_jal) || (branch == br_jalr);

  always_comb begin
    case (src1_sel)
      src1_rs1: src1 = rs1_data;
      src1_pc:  src1 = pc;
      default:  src1 = '0;
    endcase
  end

  assign src2 = is_jump ? 32'd4 : (src2_is_imm ? imm : rs2_data);

  exu u_exu (
    .src1       (src1),
    .src2       (src2),
    .alu_op     (alu_op),
    .alu_result (alu_result),
    .zero       (zero)
  );

  // Branch resolution
  always_comb begin
    case (branch)
      br_jal:  taken = 1'b1;
      br_eq:   taken = zero;
      br_ne:   taken = !zero;
      br_lt:   taken = alu_result[0];
      br_ge:   taken = !alu_result[0];
      default: taken = 1'b0;
    endcase
  end

  assign jalr_sum = rs1_data + imm;

  always_comb begin
    if (branch == br_jalr) begin
      next_pc = {jalr_sum[xlen-1:1], 1'b0};
    end else if (taken) begin
      next_pc = pc + imm;
    end else begin
      next_pc = pc + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= reset_pc;
    end else if (inst_valid) begin
      pc <= next_pc;
    end
  end

  assign wb_en   = inst_valid & reg_write;
  assign wb_rd   = rd_idx;
  assign wb_data = alu_result;
  assign illegal = inst_valid & dec_illegal;

endmodule

// ==== tests/exec_model.svh ====
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// Architectural state changed only by valid instructions
logic [31:0] m_regs [0:31];
logic [31:0] m_pc;

// RV32I OP/OP-IMM result for one funct3
function automatic logic [31:0] base_op(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] x, input logic [31:0] y);
  case (f3)
    3'd0: return alt ? x - y : x + y;
    3'd1: return x << y[4:0];
    3'd2: return {31'b0, $signed(x) < $signed(y)};
    3'd3: return {31'b0, x < y};
    3'd4: return x ^ y;
    3'd5: begin
      if (alt) return $signed(x) >>> y[4:0];
      return x >> y[4:0];
    end
    3'd6: return x | y;
    default: return x & y;
  endcase
endfunction

// M extension result on 64 bits so signed overflow wraps like RISC-V
function automatic logic [31:0] muldiv_op(input logic [2:0] f3,
                                          input logic [31:0] x, input logic [31:0] y);
  longint sx, sy, q;
  logic [63:0] p;
  p = {32'b0, x} * {32'b0, y};
  if (!f3[2]) return f3[1] ? p[63:32] : p[31:0];
  if (y == 32'd0) return f3[1] ? x : '1;
  sx = f3[0] ? longint'(x) : longint'($signed(x));
  sy = f3[0] ? longint'(y) : longint'($signed(y));
  q = f3[1] ? sx % sy : sx / sy;
  return q[31:0];
endfunction

// Expected outputs of one valid instruction and its effect on the state
task automatic model_exec(input logic [31:0] i, output logic en, output logic [4:0] rd,
                          output logic [31:0] res, output logic bad);
  logic [31:0] a, b, imm_i, nxt;
  logic [2:0] f3;
  logic take;
  a = m_regs[i[19:15]];
  b = m_regs[i[24:20]];
  imm_i = {{20{i[31]}}, i[31:20]};
  f3 = i[14:12];
  rd = i[11:7];
  en = 1'b1;
  bad = 1'b0;
  take = 1'b0;
  res = m_pc + 32'd4;
  nxt = m_pc + 32'd4;
  case (i[6:0])
    7'b0110111: res = {i[31:12], 12'b0};
    7'b0010111: res = m_pc + {i[31:12], 12'b0};
    7'b1101111: nxt = m_pc + {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
    7'b1100111: begin
      nxt = (a + imm_i) & ~32'd1;
      bad = (f3 != 3'd0);
    end
    7'b1100011: begin
      en = 1'b0;
      case (f3)
        3'd0: take = (a == b);
        3'd1: take = (a != b);
        3'd4: take = ($signed(a) < $signed(b));
        3'd5: take = ($signed(a) >= $signed(b));
        3'd6: take = (a < b);
        3'd7: take = (a >= b);
        default: bad = 1'b1;
      endcase
      if (take) nxt = m_pc + {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
    end
    7'b0010011: begin
      res = base_op(f3, (f3 == 3'd5) && i[30], a, imm_i);
      bad = (f3 == 3'd1 && i[31:25] != 7'h00) || (f3 == 3'd5 && {i[31], i[29:25]} != 6'h00);
    end
    7'b0110011: begin
      if (i[31:25] == 7'h01) begin
        res = muldiv_op(f3, a, b);
        bad = (f3 == 3'd1) || (f3 == 3'd2);
      end else begin
        res = base_op(f3, i[30], a, b);
        bad = ({i[31], i[29:25]} != 6'h00) || (i[30] && f3 != 3'd0 && f3 != 3'd5);
      end
    end
    default: bad = 1'b1;
  endcase
  if (bad) begin
    en = 1'b0;
    nxt = m_pc + 32'd4;
  end
  if (en && rd != 5'd0) m_regs[rd] = res;
  m_pc = nxt;
endtask

`endif

// ==== tests/tb_core_exec.sv ====
module tb_core_exec;

  `include "exec_model.svh"

  logic        clk;
  logic        reset;
  logic        inst_valid;
  logic [31:0] inst;
  logic [31:0] pc;
  logic        wb_en;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;
  logic        illegal;

  logic [31:0] rng_state = 32'd72952;
  int          errors;
  int          test_errors;
  int          failed_tests;

  // {funct7, funct3} of every supported OP encoding with the M extension last
  logic [9:0] reg_ops [16] = '{10'h000, 10'h001, 10'h002, 10'h003, 10'h004, 10'h005,
                               10'h006, 10'h007, 10'h100, 10'h105, 10'h008, 10'h00b,
                               10'h00c, 10'h00d, 10'h00e, 10'h00f};

  core_exec dut0 (.*);

  always #2 clk = ~clk;

  function automatic logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    if (actual !== expected) begin
      $display("ERR %0t %s: got %h, expected %h", $time, what, actual, expected);
      test_errors++;
    end
  endtask

  task automatic report_test(input string name);
    $display("test %s: %s, %0d mismatches", name, (test_errors == 0) ? "passed" : "failed",
             test_errors);
    errors += test_errors;
    if (test_errors != 0) failed_tests++;
    test_errors = 0;
  endtask

  // Drive at edge + 1 and sample just before the next edge
  task automatic step(input logic [31:0] word, input logic valid);
    logic        e_en;
    logic [4:0]  e_rd;
    logic [31:0] e_data;
    logic        e_ill;
    inst = word;
    inst_valid = valid;
    e_en = 1'b0;
    e_ill = 1'b0;
    #2;
    check(pc, m_pc, "pc");
    if (valid) model_exec(word, e_en, e_rd, e_data, e_ill);
    check(32'(wb_en), 32'(e_en), "wb_en");
    check(32'(illegal), 32'(e_ill), "illegal");
    if (e_en) begin
      check(32'(wb_rd), 32'(e_rd), "wb_rd");
      check(wb_data, e_data, "wb_data");
    end
    @(posedge clk);
    #1;
  endtask

  // Random legal instruction of kind 0 (register ALU), 1 (immediate) or 2 (control flow)
  function automatic logic [31:0] gen_inst(input int kind);
    logic [31:0] r;
    r = next_random();
    if (kind == 0) return {reg_ops[r[3:0]][9:3], r[24:15], reg_ops[r[3:0]][2:0], r[11:7],
                           7'b0110011};
    if (kind == 1) begin
      if (r[1:0] == 2'd0) return {r[31:7], 7'b0110111};
      if (r[1:0] == 2'd1) return {r[31:7], 7'b0010111};
      if (r[13:12] == 2'b01) r[31:25] = {1'b0, r[30] & r[14], 5'b0};
      return {r[31:7], 7'b0010011};
    end
    // Same source register on both ports now and then so BEQ can be taken
    if (r[0]) r[24:20] = r[19:15];
    case (r[3:1])
      3'd0: return {r[31:7], 7'b1101111};
      3'd1: return {r[31:15], 3'd0, r[11:7], 7'b1100111};
      3'd2, 3'd3: return {r[31:15], 2'b00, r[12], r[11:7], 7'b1100011};
      default: return {r[31:15], 1'b1, r[13:12], r[11:7], 7'b1100011};
    endcase
  endfunction

  initial begin
    logic [31:0] r;
    logic [31:0] v;
    int n;
    clk = 1'b0;
    reset = 1'b1;
    inst_valid = 1'b0;
    inst = '0;
    errors = 0;
    test_errors = 0;
    failed_tests = 0;
    for (int k = 0; k < 32; k++) m_regs[k] = '0;
    m_pc = '0;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    n = 0;
    while (pc !== 32'd0 && n < 10) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (pc !== 32'd0) begin
      $display("pc never returned to zero after reset");
      test_errors++;
    end
    repeat (6) step(next_random(), 1'b0);
    report_test("1 reset");

    // Registers read zero out of reset
    for (int k = 1; k < 32; k++) step({12'h000, 5'(k), 3'b110, 5'd0, 7'b0010011}, 1'b1);
    // Seed x1..x31 with LUI + ADDI
    // x1..x3 hold zero, minus one and the most negative value
    for (int k = 1; k < 32; k++) begin
      v = (k == 1) ? 32'd0 : (k == 2) ? '1 : (k == 3) ? 32'h8000_0000 : next_random();
      r = v + 32'h800;
      step({r[31:12], 5'(k), 7'b0110111}, 1'b1);
      step({v[11:0], 5'(k), 3'b000, 5'(k), 7'b0010011}, 1'b1);
    end
    for (int k = 10; k < 16; k++) begin
      step({reg_ops[k][9:3], 5'd2, 5'd3, reg_ops[k][2:0], 5'd4, 7'b0110011}, 1'b1);
      step({reg_ops[k][9:3], 5'd0, 5'd3, reg_ops[k][2:0], 5'd4, 7'b0110011}, 1'b1);
    end
    repeat (200) step(gen_inst(0), 1'b1);
    report_test("2 alu_reg");

    repeat (200) step(gen_inst(1), 1'b1);
    report_test("3 immediates");

    repeat (200) step(gen_inst(2), 1'b1);
    report_test("4 control_flow");

    repeat (40) begin
      r = next_random();
      case (r[1:0])
        2'd0: step({r[31:7], 7'b0000011}, 1'b1);
        2'd1: step({r[31:7], 7'b0100011}, 1'b1);
        2'd2: step({7'h01, r[24:15], 1'b0, r[13], ~r[13], r[11:7], 7'b0110011}, 1'b1);
        default: step({r[31:7], 7'b1110011}, 1'b1);
      endcase
      // Read the destination back through ORI into x0
      step({12'h000, r[11:7], 3'b110, 5'd0, 7'b0010011}, 1'b1);
    end
    report_test("5 illegal");

    repeat (300) begin
      r = next_random();
      step(gen_inst(int'(r % 3)), r[31:30] != 2'b00);
    end
    step(32'd0, 1'b0);
    report_test("6 gaps");

    $display("tests run: 6, tests failed: %0d, mismatches: %0d", failed_tests, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #40000;
    $display("Simulation ran past its time limit");
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+tests
common/exec_pkg.sv
exu/exu.sv
design/idu.sv
design/regfile.sv
design/core_exec.sv
tests/tb_core_exec.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing
TOP       := tb_core_exec
FLIST     := flist.f

BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := common/exec_pkg.sv exu/exu.sv design/idu.sv design/regfile.sv \
             design/core_exec.sv tests/tb_core_exec.sv tests/exec_model.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
